//--- hdl/cmd_latch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command latch
// keeps function key and quit presses pending until the sequencer serves them
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cmd_latch
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cmd_word_t  cmd,
    input  logic [3:0] clr,     // one-hot, pulsed when a command is served
    output logic [3:0] pending  // bit 0 F1, 1 F2, 2 F3, 3 quit
);

    logic [3:0] press; // this cycle's pulses in pending order

    assign press = {cmd.quit, cmd.fkey};

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 4'd0;
        end else begin
            // a new press in the clearing cycle stays pending
            pending <= (pending & ~clr) | press;
        end
    end

endmodule

//--- hdl/ctrl_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control types of the play engine
// opcodes, the keyboard command word and the sweep position
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ctrl_pkg;

    // one opcode runs per full sweep of the tile map
    typedef enum logic [2:0] {
        OP_IDLE,
        OP_BOOT,
        OP_NEW_GAME,
        OP_NEW_LEVEL,
        OP_TRASH
    } opcode_t;

    // layout of the keyboard lookup table, every bit is a one-cycle pulse
    typedef struct packed {
        logic       repeat_move; // modifier for the move bits
        logic       teleport;
        logic       wait_cmd;
        logic       turn;
        logic       quit;        // q, esc, backspace
        logic [2:0] fkey;        // F3, F2, F1
        logic [7:0] move_dir;    // E SE S SW W NW N NE
    } cmd_word_t;

    // where the sweep is now
    typedef struct packed {
        logic [2:0] phase; // 0..4 within one address
        logic [6:0] col;   // 127 down to 0
        logic [5:0] pair;  // 47 down to 0
    } sweep_pos_t;

endpackage

//--- hdl/field_filler.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// field filler
// prng, robot density and player placement for the new level play area
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "robots_params.svh"

module field_filler
    import ctrl_pkg::*, tile_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       level_inc,
    input  logic       score_clear,
    input  sweep_pos_t pos,
    input  logic       pair_start,
    output tile_byte_u fill_byte,
    output tile_byte_u trash_byte
);

    // x^29 + x^27 + 1, eight shifts per clock
    function automatic logic [28:0] lfsr_step8(input logic [28:0] s);
        logic [28:0] r;
        r = s;
        for (int i = 0; i < 8; i++) begin
            r = {r[27:0], r[28] ^ r[26]};
        end
        return r;
    endfunction

    logic [28:0] prng_st;
    logic [15:0] prng;        // latest two clocks of output
    logic [11:0] robot_prob;  // per 65536 cells
    logic        place_robot;
    logic        robot_upper; // upper cell decision held from phase 0
    logic [6:0]  player_x;
    logic [6:0]  player_y;    // cell row, 16..79
    logic [2:0]  y_mid;
    logic        player_pair;

    assign prng        = prng_st[15:0];
    assign place_robot = (prng < {4'd0, robot_prob});
    assign y_mid       = {1'b0, prng[12:11]} + 3'd1;
    assign player_pair = (pos.col == player_x) && (pos.pair == player_y[6:1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            prng_st     <= `PRNG_SEED;
            robot_prob  <= 12'd0;
            robot_upper <= 1'b0;
            player_x    <= 7'd0;
            player_y    <= 7'd0;
        end else begin
            prng_st <= lfsr_step8(prng_st);
            if (pair_start) robot_upper <= place_robot;
            if (score_clear) begin
                robot_prob <= 12'd0; // no level zero robots
                player_x   <= 7'd0;
                player_y   <= 7'd0;
            end else if (level_inc) begin
                // drop the top bit so density never wraps to zero
                robot_prob <= {1'b0, robot_prob[10:0]} + `ROBOT_PROB_STEP;
                // keep the player out of the score column
                player_x   <= (prng[6:3] == 4'hf) ? {1'b0, prng[5:0]} : prng[6:0];
                player_y   <= {y_mid, prng[10:7]};
            end
        end
    end

    always_comb begin
        fill_byte.play.temp  = 4'd0;
        if (player_pair && player_y[0])
            fill_byte.play.lower = CELL_PLAYER;
        else
            fill_byte.play.lower = place_robot ? CELL_ROBOT : CELL_EMPTY;
        if (player_pair && !player_y[0])
            fill_byte.play.upper = CELL_PLAYER;
        else
            fill_byte.play.upper = robot_upper ? CELL_ROBOT : CELL_EMPTY;
    end

    assign trash_byte = prng[7:0]; // raw garbage, any cell codes

endmodule

//--- hdl/play_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// play sequencer
// opcode FSM, serves pending commands and owns the tile map bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "robots_params.svh"

module play_sequencer
    import ctrl_pkg::*, tile_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] pending,    // F1, F2, F3, quit
    output logic [3:0] clr,
    output logic       run,
    input  sweep_pos_t pos,
    input  logic       score_col,
    input  logic       sweep_done,
    input  logic       pair_start,
    input  logic       skw_wen,
    input  tile_byte_u skw_byte,
    input  tile_byte_u fill_byte,
    input  tile_byte_u trash_byte,
    output logic       level_inc,
    output logic       score_inc,
    output logic       score_clear,
    output logic       want_attention,
    output logic       busy,
    output tile_bus_t  tm
);

    opcode_t op;
    opcode_t op_next;
    logic    first_adr; // first address of a sweep

    assign run = (op == OP_NEW_GAME) || (op == OP_NEW_LEVEL) || (op == OP_TRASH);
    assign first_adr = pair_start && (pos.col == 7'(`FIELD_COLS - 1))
                       && (pos.pair == 6'(`ROW_PAIRS - 1));

    always_comb begin
        op_next        = op;
        clr            = 4'd0;
        level_inc      = 1'b0;
        score_inc      = 1'b0;
        score_clear    = 1'b0;
        want_attention = 1'b0;
        tm.adr         = {pos.pair, pos.col}; // reads follow the sweep
        tm.wrt         = skw_byte;
        tm.wen         = 1'b0;
        case (op)
            OP_IDLE: begin
                if (pending[2]) begin          // F3 trash, one point
                    clr[2]    = 1'b1;
                    score_inc = 1'b1;
                    op_next   = OP_TRASH;
                end else if (pending[0]) begin // F1 skip to next level
                    clr[0]    = 1'b1;
                    level_inc = 1'b1;
                    op_next   = OP_NEW_LEVEL;
                end else if (pending[1]) begin // F2 beep only
                    clr[1]         = 1'b1;
                    want_attention = 1'b1;
                end else if (pending[3]) begin // quit
                    clr[3]      = 1'b1;
                    score_clear = 1'b1;
                    op_next     = OP_NEW_GAME;
                end
            end
            OP_BOOT: begin
                score_clear = 1'b1;
                op_next     = OP_NEW_GAME;
            end
            OP_NEW_GAME: begin
                level_inc = first_adr; // level 1 of the new game
                if (sweep_done) begin
                    op_next = OP_NEW_LEVEL;
                end
            end
            OP_NEW_LEVEL, OP_TRASH: begin
                if (score_col) begin
                    tm.wen = skw_wen;
                    tm.wrt = skw_byte;
                end else if (op == OP_NEW_LEVEL) begin
                    tm.wen = (pos.phase == 3'd3); // lower cell decided this phase
                    tm.wrt = fill_byte;
                end else begin
                    tm.wen = pair_start;
                    tm.wrt = trash_byte;
                end
                if (sweep_done) begin
                    op_next = OP_IDLE;
                end
            end
            default: op_next = OP_IDLE;
        endcase
    end

    // covers the dispatch cycle too, F2 never leaves idle
    assign busy = (op != OP_IDLE) || (op_next != OP_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            op <= OP_BOOT;
        end else begin
            op <= op_next;
        end
    end

endmodule

//--- hdl/robots_params.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// robots play engine constants
// map geometry, sweep timing, score tags, robot density and prng seed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ROBOTS_PARAMS_SVH
`define ROBOTS_PARAMS_SVH

`define FIELD_COLS      128     // cells per row
`define ROW_PAIRS       48      // each map byte holds two vertically stacked cells
`define ADR_W           13      // {row pair, column}
`define SWEEP_PHASES    5       // clocks spent on each address
`define SCORE_COL_BASE  120     // columns 120..127 hold the score display
`define TAG_LEVEL       3'd5
`define TAG_SCORE       3'd6
`define TAG_HIGH        3'd7
`define BLANK_DIGIT     4'd10   // font slot drawn as a space
`define LEVEL_DIGITS    2
`define SCORE_DIGITS    6
`define ROBOT_PROB_STEP 12'd171 // per level, in units of 1/65536 per cell
`define PRNG_SEED       29'd1

`endif

//--- hdl/robots_play_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// robots play engine
// reacts to key commands by sweeping and rewriting the tile map
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "robots_params.svh"

module robots_play_top
    import ctrl_pkg::*, tile_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cmd_word_t  cmd,
    input  tile_byte_u tm_red,         // byte at last cycle's address
    output tile_bus_t  tm,
    output logic       want_attention,
    output logic       busy
);

    logic [3:0] pending, clr;
    logic       run, pair_start, score_col, sweep_done;
    sweep_pos_t pos;
    logic       level_inc, score_inc, score_clear;
    logic       skw_wen;
    tile_byte_u skw_byte, fill_byte, trash_byte;

    logic [`LEVEL_DIGITS*4-1:0] level;
    logic [`SCORE_DIGITS*4-1:0] score, high;
    logic [`LEVEL_DIGITS-1:0]   level_mask;
    logic [`SCORE_DIGITS-1:0]   score_mask, high_mask;

    cmd_latch u_cmd (
        .clk, .rst, .cmd, .clr, .pending
    );

    sweep_counter u_sweep (
        .clk, .rst, .run, .pos, .pair_start, .score_col, .sweep_done
    );

    play_sequencer u_seq (
        .clk, .rst, .pending, .clr, .run, .pos, .score_col, .sweep_done, .pair_start,
        .skw_wen, .skw_byte, .fill_byte, .trash_byte,
        .level_inc, .score_inc, .score_clear, .want_attention, .busy, .tm
    );

    score_keeper u_keep (
        .clk, .rst, .score_clear, .level_inc, .score_inc,
        .level, .score, .high, .level_mask, .score_mask, .high_mask
    );

    score_writer u_skw (
        .clk, .rst,
        .sample (score_col && (pos.phase == 3'd1)), // read data of this address is back
        .tm_red, .level, .level_mask, .score, .score_mask, .high, .high_mask,
        .skw_wen, .skw_byte
    );

    field_filler u_fill (
        .clk, .rst, .level_inc, .score_clear, .pos, .pair_start,
        .fill_byte, .trash_byte
    );

endmodule

//--- hdl/score_keeper.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// score keeper
// decimal level, score and high score with leading zero masks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "robots_params.svh"

module score_keeper (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         score_clear,
    input  logic                         level_inc,
    input  logic                         score_inc,
    output logic [`LEVEL_DIGITS*4-1:0]   level,
    output logic [`SCORE_DIGITS*4-1:0]   score,
    output logic [`SCORE_DIGITS*4-1:0]   high,
    output logic [`LEVEL_DIGITS-1:0]     level_mask,
    output logic [`SCORE_DIGITS-1:0]     score_mask,
    output logic [`SCORE_DIGITS-1:0]     high_mask
);

    localparam int ND = `SCORE_DIGITS;
    localparam int SW = ND * 4;
    localparam int LW = `LEVEL_DIGITS * 4;

    // ripple carry through packed bcd digits
    function automatic logic [SW-1:0] bcd_inc(input logic [SW-1:0] v);
        logic [SW-1:0] r;
        logic          carry;
        r     = v;
        carry = 1'b1;
        for (int i = 0; i < ND; i++) begin
            if (carry) begin
                if (r[i*4 +: 4] == 4'd9) begin
                    r[i*4 +: 4] = 4'd0;
                end else begin
                    r[i*4 +: 4] = r[i*4 +: 4] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
        return r;
    endfunction

    // a digit is hidden when it and everything above it is zero, digit 0 always shows
    function automatic logic [ND-1:0] lead_mask(input logic [SW-1:0] v);
        logic [ND-1:0] m;
        logic          zero_above;
        m          = '0;
        zero_above = 1'b1;
        for (int i = ND - 1; i >= 1; i--) begin
            zero_above = zero_above && (v[i*4 +: 4] == 4'd0);
            m[i]       = zero_above;
        end
        return m;
    endfunction

    logic [SW-1:0] level_up;   // level widened to score width
    logic [SW-1:0] score_up;
    logic [SW-1:0] high_up;
    logic [ND-1:0] level_mask_w;

    assign level_up     = bcd_inc(SW'(level));
    assign score_up     = bcd_inc(score);
    assign high_up      = bcd_inc(high);
    assign level_mask_w = lead_mask(SW'(level));
    assign level_mask   = level_mask_w[`LEVEL_DIGITS-1:0];
    assign score_mask   = lead_mask(score);
    assign high_mask    = lead_mask(high);

    always_ff @(posedge clk) begin
        if (rst) begin
            level <= '0;
            score <= '0;
            high  <= '0;
        end else begin
            if (score_clear) begin
                level <= '0; // high score survives a new game
                score <= '0;
            end else begin
                if (level_inc) level <= level_up[LW-1:0];
                if (score_inc) score <= score_up;
            end
            // high follows score while they match, no compare and copy
            if (score_inc && (score == high)) high <= high_up;
        end
    end

endmodule

//--- hdl/score_writer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// score writer
// spots score tags in the score column and draws digits leftward from them
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "robots_params.svh"

module score_writer
    import tile_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sample,     // phase 1, score column
    input  tile_byte_u                 tm_red,
    input  logic [`LEVEL_DIGITS*4-1:0] level,
    input  logic [`LEVEL_DIGITS-1:0]   level_mask,
    input  logic [`SCORE_DIGITS*4-1:0] score,
    input  logic [`SCORE_DIGITS-1:0]   score_mask,
    input  logic [`SCORE_DIGITS*4-1:0] high,
    input  logic [`SCORE_DIGITS-1:0]   high_mask,
    output logic                       skw_wen,
    output tile_byte_u                 skw_byte
);

    localparam int ND = `SCORE_DIGITS;
    localparam int SW = ND * 4;

    logic [SW-1:0] data_q, data_d;   // digits still to draw, lowest first
    logic [ND-1:0] mask_q, mask_d;
    logic [2:0]    count_q, count_d; // digits left including this one

    always_comb begin
        data_d  = data_q;
        mask_d  = mask_q;
        count_d = count_q;
        if (sample) begin
            case (tm_red.score.tag)
                `TAG_LEVEL: begin
                    data_d  = SW'(level);
                    mask_d  = {{(ND - `LEVEL_DIGITS){1'b1}}, level_mask};
                    count_d = 3'(`LEVEL_DIGITS);
                end
                `TAG_SCORE: begin
                    data_d  = score;
                    mask_d  = score_mask;
                    count_d = 3'(ND);
                end
                `TAG_HIGH: begin
                    data_d  = high;
                    mask_d  = high_mask;
                    count_d = 3'(ND);
                end
                default: begin
                    if (count_q != 3'd0) begin // next digit one cell left
                        data_d  = data_q >> 4;
                        mask_d  = {1'b1, mask_q[ND-1:1]};
                        count_d = count_q - 3'd1;
                    end
                end
            endcase
        end
        // upper nibble of the cell is kept, tag cells keep their tag
        skw_byte             = tm_red;
        skw_byte.score.digit = mask_d[0] ? `BLANK_DIGIT : data_d[3:0];
    end

    assign skw_wen = sample && (count_d != 3'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            data_q  <= '0;
            mask_q  <= '0;
            count_q <= 3'd0;
        end else if (sample) begin
            data_q  <= data_d;
            mask_q  <= mask_d;
            count_q <= count_d;
        end
    end

endmodule

//--- hdl/sweep_counter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sweep counter
// walks the tile map in reverse address order, five clocks per address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "robots_params.svh"

module sweep_counter
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       run,
    output sweep_pos_t pos,
    output logic       pair_start, // phase 0 of an address
    output logic       score_col,
    output logic       sweep_done  // last phase of address 0
);

    localparam sweep_pos_t START = '{
        phase: 3'd0,
        col:   7'(`FIELD_COLS - 1),
        pair:  6'(`ROW_PAIRS - 1)
    };
    localparam logic [2:0] LAST_PHASE = 3'(`SWEEP_PHASES - 1);

    logic last_phase;

    assign last_phase = (pos.phase == LAST_PHASE);

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pos <= START; // parked at the top right corner
        end else if (!last_phase) begin
            pos.phase <= pos.phase + 3'd1;
        end else begin
            pos.phase <= 3'd0;
            if (pos.col != 7'd0) begin
                pos.col <= pos.col - 7'd1; // next pair to the left
            end else begin
                pos.col  <= START.col;
                // wraps back to the top after address 0
                pos.pair <= (pos.pair != 6'd0) ? pos.pair - 6'd1 : START.pair;
            end
        end
    end

    assign pair_start = (pos.phase == 3'd0);
    assign score_col  = (pos.col >= 7'(`SCORE_COL_BASE));
    assign sweep_done = run && last_phase && (pos.col == 7'd0) && (pos.pair == 6'd0);

endmodule

//--- hdl/tile_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile map types
// cell codes, the tile byte seen as play cells or score digit, memory bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "robots_params.svh"

package tile_pkg;

    typedef enum logic [1:0] {
        CELL_EMPTY,
        CELL_ROBOT,
        CELL_TRASH,
        CELL_PLAYER
    } cell_t;

    // left of the score column a byte is two cells, inside it a tagged digit
    typedef union packed {
        struct packed {
            logic [3:0] temp;  // scratch, invisible on screen
            cell_t      lower;
            cell_t      upper;
        } play;
        struct packed {
            logic [2:0] tag;   // 5 level, 6 score, 7 high score
            logic       spare;
            logic [3:0] digit;
        } score;
    } tile_byte_u;

    typedef struct packed {
        logic [`ADR_W-1:0] adr;
        tile_byte_u        wrt;
        logic              wen;
    } tile_bus_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# build the robots play engine testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

TOP=tb_robots_play
LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- src.f
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/tile_pkg.sv
hdl/cmd_latch.sv
hdl/sweep_counter.sv
hdl/play_sequencer.sv
hdl/score_keeper.sv
hdl/score_writer.sv
hdl/field_filler.sv
hdl/robots_play_top.sv
test/tb_robots_play.sv

//--- test/play_stim.txt
# columns: command letter, expected level, expected score, expected high score
# R boot wait, L F1 next level, T F3 trash, B F2 attention, Q quit
R 1 0 0
T 1 1 1
T 1 2 2
B 1 2 2
L 2 2 2
T 2 3 3
Q 1 0 3
T 1 1 3
L 2 1 3
T 2 2 3
T 2 3 3
T 2 4 4
B 2 4 4

//--- test/tb_robots_play.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// robots play engine testbench
// tile memory model, commands from the stim file, score and play field checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "robots_params.svh"

module tb_robots_play
    import ctrl_pkg::*, tile_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SWEEP_CYCLES = `FIELD_COLS * `ROW_PAIRS * `SWEEP_PHASES;
    localparam int MEM_BYTES    = `FIELD_COLS * `ROW_PAIRS;
    localparam int MAX_GAP      = 16;              // idle cycles between commands
    localparam int TAG_COL      = `FIELD_COLS - 1; // tags sit at the right edge
    localparam int LEVEL_PAIR   = 40;
    localparam int SCORE_PAIR   = 42;
    localparam int HIGH_PAIR    = 44;

    logic       clk;
    logic       rst;
    cmd_word_t  cmd;
    tile_byte_u tm_red = '0;
    tile_bus_t  tm;
    logic       want_attention;
    logic       busy;

    tile_byte_u mem [MEM_BYTES]; // the tile map

    byte step_cmd[$];     // one entry per stim line
    int  step_level[$];
    int  step_score[$];
    int  step_high[$];
    bit  steps_loaded = 1'b0;
    int  error_count  = 0;
    int  check_count  = 0;
    int  attn_pulses  = 0; // want_attention cycles seen so far
    int  busy_cycles  = 0;

    robots_play_top UUT (.clk, .rst, .cmd, .tm_red, .tm, .want_attention, .busy);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one cycle read latency, old data on a same cycle write
    always @(posedge clk) begin
        tm_red <= mem[tm.adr];
        if (tm.wen) mem[tm.adr] <= tm.wrt;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (want_attention) attn_pulses++;
            if (busy) busy_cycles++;
        end
    end

    task automatic value_error(input string msg);
        error_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    // digit i of a decimal value as drawn, leading zeros blank except digit 0
    function automatic logic [3:0] expect_digit(input int value, input int idx);
        int p;
        p = 1;
        for (int k = 0; k < idx; k++) p = p * 10;
        if (idx > 0 && value < p) return `BLANK_DIGIT;
        return 4'((value / p) % 10);
    endfunction

    task automatic preload_memory();
        logic [`ADR_W-1:0] a;
        for (int i = 0; i < MEM_BYTES; i++) begin
            a = `ADR_W'(i);
            if (int'(a[6:0]) >= `SCORE_COL_BASE) mem[i] = 8'h00; // score column starts empty
            else mem[i] = a[7:0] ^ {3'b000, a[12:8]};             // junk the fill must clear
        end
        mem[LEVEL_PAIR * `FIELD_COLS + TAG_COL] = {`TAG_LEVEL, 1'b1, 4'h0}; // spare set
        mem[SCORE_PAIR * `FIELD_COLS + TAG_COL] = {`TAG_SCORE, 1'b1, 4'h0};
        mem[HIGH_PAIR * `FIELD_COLS + TAG_COL]  = {`TAG_HIGH, 1'b1, 4'h0};
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        string line;
        byte   letter;
        int    lvl;
        int    scr;
        int    hi;
        fd = $fopen("test/play_stim.txt", "r");
        if (fd == 0) begin
            note_failure("stim file test/play_stim.txt could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line[0] != 8'h23) begin // skip '#' lines
                n = $sscanf(line, "%c %d %d %d", letter, lvl, scr, hi);
                if (n == 4) begin
                    step_cmd.push_back(letter);
                    step_level.push_back(lvl);
                    step_score.push_back(scr);
                    step_high.push_back(hi);
                end
            end
        end
        $fclose(fd);
        if (step_cmd.size() == 0) note_failure("stim file holds no steps");
    endtask

    // tag cell holds digit 0, higher digits go one column left each
    task automatic check_counter(input string name, input int pair, input logic [2:0] tag,
                                 input int ndigits, input int value);
        tile_byte_u b;
        int         adr;
        adr = pair * `FIELD_COLS + TAG_COL;
        b = mem[adr];
        check_count++;
        if (b[7:4] != {tag, 1'b1})
            value_error($sformatf("%s tag byte upper nibble changed, byte %02h", name, b));
        for (int i = 0; i < ndigits; i++) begin
            b = mem[adr - i];
            check_count++;
            if (b.score.digit != expect_digit(value, i) || (i > 0 && b[7:4] != 4'h0))
                value_error($sformatf("%s digit %0d byte %02h, expected digit %0d of %0d",
                                      name, i, b, expect_digit(value, i), value));
        end
        b = mem[adr - ndigits];
        check_count++;
        if (b != 8'h00)
            value_error($sformatf("cell left of the %s digits became %02h", name, b));
    endtask

    task automatic check_play_field();
        tile_byte_u b;
        int         players;
        int         row;
        int         bad;
        string      first_bad;
        players = 0;
        row     = -1;
        bad     = 0;
        for (int p = 0; p < `ROW_PAIRS; p++) begin
            for (int c = 0; c < `SCORE_COL_BASE; c++) begin
                b = mem[p * `FIELD_COLS + c];
                if (b.play.temp != 4'h0 || b.play.lower == CELL_TRASH
                    || b.play.upper == CELL_TRASH) begin
                    if (bad == 0) first_bad = $sformatf("pair %0d col %0d = %02h", p, c, b);
                    bad++;
                end
                if (b.play.upper == CELL_PLAYER) begin
                    players++;
                    row = 2 * p;     // upper cell is the even row
                end
                if (b.play.lower == CELL_PLAYER) begin
                    players++;
                    row = 2 * p + 1;
                end
            end
        end
        check_count += 3;
        if (bad != 0)
            value_error($sformatf("%0d play bytes with trash or temp bits, first %s",
                                  bad, first_bad));
        if (players != 1) value_error($sformatf("%0d player cells after new level", players));
        if (players == 1 && (row < 16 || row > 79))
            value_error($sformatf("player placed on row %0d", row));
    endtask

    task automatic press_key(input byte letter);
        @(posedge clk);
        #1;
        case (letter)
            "L": cmd.fkey[0] = 1'b1; // F1
            "B": cmd.fkey[1] = 1'b1; // F2
            "T": cmd.fkey[2] = 1'b1; // F3
            "Q": cmd.quit    = 1'b1;
            default: note_failure($sformatf("unknown command letter %c in stim", letter));
        endcase
        @(posedge clk);
        #1;
        cmd = '0; // one cycle pulse
    endtask

    task automatic wait_busy_rise(output bit rose);
        rose = 1'b0;
        for (int n = 0; n < 8 && !rose; n++) begin
            @(negedge clk);
            rose = busy;
        end
    endtask

    task automatic run_step(input int s);
        byte letter;
        int  attn_before;
        int  busy_before;
        int  gap;
        bit  rose;
        letter      = step_cmd[s];
        attn_before = attn_pulses;
        busy_before = busy_cycles;
        if (letter != "R") begin
            gap = 1 + int'($urandom % MAX_GAP);
            repeat (gap) @(posedge clk);
            press_key(letter);
        end
        if (letter == "B") begin
            repeat (6) @(negedge clk); // latch, serve and a few spare cycles
            check_count += 2;
            if (attn_pulses != attn_before + 1)
                value_error($sformatf("F2 gave %0d attention cycles",
                                      attn_pulses - attn_before));
            if (busy_cycles != busy_before) value_error("busy rose during F2");
        end else begin
            if (letter != "R") begin
                wait_busy_rise(rose);
                if (!rose) note_failure($sformatf("step %0d command was never taken up", s));
            end
            while (busy) @(negedge clk);
            check_count++;
            if (attn_pulses != attn_before) value_error("want_attention pulsed outside F2");
        end
        check_counter("level", LEVEL_PAIR, `TAG_LEVEL, `LEVEL_DIGITS, step_level[s]);
        check_counter("score", SCORE_PAIR, `TAG_SCORE, `SCORE_DIGITS, step_score[s]);
        check_counter("high score", HIGH_PAIR, `TAG_HIGH, `SCORE_DIGITS, step_high[s]);
        if (letter == "R" || letter == "L" || letter == "Q") check_play_field();
    endtask

    initial begin
        void'($urandom(32'h3c76ec1e));
        rst = 1'b1;
        cmd = '0;
        preload_memory();
        load_stim();
        steps_loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0; // boot starts right away
        for (int s = 0; s < step_cmd.size(); s++) run_step(s);
        $display("steps %0d, checks %0d, errors %0d", step_cmd.size(), check_count,
                 error_count);
        if (error_count == 0 && step_cmd.size() > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // up to three sweeps per step plus the idle gap
    initial begin
        time budget;
        wait (steps_loaded);
        budget = time'(step_cmd.size()) * time'(3 * SWEEP_CYCLES + MAX_GAP + 20) * 10 + 10000;
        #(budget);
        $display("watchdog expired at %0t, the engine stayed busy too long", $time);
        $display("TB FAILED");
        $finish;
    end

endmodule
